// File: build.sh
#!/bin/sh
# Compile and run the saturnBus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f saturnBus.f \
	--top-module saturnBusTb \
	-o saturnBusSim

# Keep running past failed assertions so the testbench can report them
status=0
./obj_dir/saturnBusSim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit "$status"

// File: rtl/busReturnMux.sv
module busReturnMux (
	input  saturnBusPkg::busRegionT region,
	input  saturnBusPkg::busDataT   memRdData,
	input  saturnBusPkg::byteT      smpcRdData,
	input  saturnBusPkg::subDataT   cartRdData,
	input  saturnBusPkg::subDataT   cdRdData,
	input  saturnBusPkg::subDataT   vdp1RdData,
	input  saturnBusPkg::subDataT   vdp2RdData,
	input  saturnBusPkg::subDataT   scspRdData,
	output saturnBusPkg::busDataT   cpuRdData
);

	saturnBusPkg::subDataT aData;
	saturnBusPkg::subDataT bData;

	// A-bus return, idle lines float high
	always_comb begin
		case (region)
			saturnBusPkg::regCart: aData = cartRdData;
			saturnBusPkg::regCd:   aData = cdRdData;
			default:               aData = '1;
		endcase
	end

	// B-bus return, empty slots read zero
	always_comb begin
		case (region)
			saturnBusPkg::regVdp1: bData = vdp1RdData;
			saturnBusPkg::regVdp2: bData = vdp2RdData;
			saturnBusPkg::regScsp: bData = scspRdData;
			default:               bData = '0;
		endcase
	end

	always_comb begin
		case (region)
			saturnBusPkg::regRom, saturnBusPkg::regSram,
			saturnBusPkg::regRamL, saturnBusPkg::regRamH:
				cpuRdData = memRdData;
			saturnBusPkg::regSmpc:
				cpuRdData = {4{smpcRdData}}; // Byte register on every lane
			saturnBusPkg::regCart, saturnBusPkg::regCd, saturnBusPkg::regAbusNone:
				cpuRdData = {2{aData}};
			saturnBusPkg::regVdp1, saturnBusPkg::regVdp2, saturnBusPkg::regScsp:
				cpuRdData = {2{bData}};
			default:
				cpuRdData = '0;
		endcase
	end

endmodule

// File: rtl/cdRamPort.sv
`include "saturnBus_config.svh"

module cdRamPort (
	input  saturnBusPkg::cdAddrT    shAddr,
	input  saturnBusPkg::subDataT   shWrData,
	input  saturnBusPkg::subDataT   dmaData,
	input  saturnBusPkg::subDataT   cdRamRdData,
	input  saturnBusPkg::subDataT   ctrlRdData,
	input  logic                    shCs1N,
	input  logic                    shRdN,
	input  logic                    shWrLN,
	input  logic                    shWrHN,
	input  logic                    cdRamRdy,
	input  logic [1:0]              dmaAckN,
	output saturnBusPkg::cdRamAddrT cdRamAddr,
	output saturnBusPkg::subDataT   cdRamWrData,
	output saturnBusPkg::subDataT   shRdData,
	output logic [1:0]              cdRamWe,
	output logic                    cdRamRd,
	output logic                    cdRamCs,
	output logic                    shWait
);

	logic dmaActive;

	// Either DMA channel acknowledged
	assign dmaActive = !dmaAckN[0] || !dmaAckN[1];

	assign cdRamAddr   = shAddr[`SATURN_CD_RAM_ADDR_W-1:0];
	assign cdRamWrData = dmaActive ? dmaData : shWrData;

	// CS1 space is CD RAM, everything else comes from the controller
	assign shRdData = !shCs1N ? cdRamRdData : ctrlRdData;

	assign cdRamCs = ~shCs1N;
	assign cdRamRd = ~shRdN;
	assign cdRamWe = ~{shWrHN, shWrLN}; // Upper lane in bit 1

	assign shWait = cdRamRdy;

endmodule

// File: rtl/clockResetGen.sv
module clockResetGen (
	input  logic CLK,
	input  logic RST_N,
	input  logic cdCe,
	input  logic smpcCe,
	output logic shCeR,
	output logic shCeF,
	output logic mresN
);

	logic shPhase; // Half-rate SH1 clock level

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			shPhase <= 1'b0;
		end else if (cdCe) begin
			shPhase <= ~shPhase;
		end
	end

	// Falling edge comes first out of reset
	assign shCeF = cdCe && !shPhase;
	assign shCeR = cdCe && shPhase;

	// Master reset held until the SMPC starts ticking
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (smpcCe) begin
			mresN <= 1'b1;
		end
	end

endmodule

// File: rtl/cpuBusDecode.sv
`include "saturnBus_config.svh"

module cpuBusDecode (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    cpuStart,
	input  logic                    cpuRead,
	input  saturnBusPkg::busAddrT   cpuAddr,
	input  logic                    memRdy,
	input  logic                    aBusRdy,
	input  logic                    bBusRdy,
	output saturnBusPkg::busRegionT region,
	output saturnBusPkg::busAddrT   memAddr,
	output logic                    romCsN,
	output logic                    sramCsN,
	output logic                    ramLCsN,
	output logic                    ramHCsN,
	output logic                    memRdN,
	output logic                    aCsN,
	output logic                    bCsN,
	output logic                    cpuDone,
	output logic [`SATURN_SUBREGION_HI-`SATURN_SUBREGION_LO:0] aSel,
	output logic [`SATURN_SUBREGION_HI-`SATURN_SUBREGION_LO:0] bSel
);

	localparam int RegW = `SATURN_REGION_HI - `SATURN_REGION_LO + 1;
	localparam int SubW = `SATURN_SUBREGION_HI - `SATURN_SUBREGION_LO + 1;

	saturnBusPkg::accessStateT state;
	saturnBusPkg::busRegionT   nextRegion;
	logic [RegW-1:0]           granule;
	logic [SubW-1:0]           sub;
	logic                      readQ;
	logic                      regionRdy;
	logic                      inAccess;
	logic                      isMem;
	logic                      accept;

	assign granule = cpuAddr[`SATURN_REGION_HI:`SATURN_REGION_LO];
	assign sub     = cpuAddr[`SATURN_SUBREGION_HI:`SATURN_SUBREGION_LO];

	always_comb begin
		nextRegion = saturnBusPkg::regNone;
		if (granule == RegW'(0)) nextRegion = saturnBusPkg::regRom;
		else if (granule == RegW'(1)) begin
			// SMPC and backup SRAM share the second granule
			nextRegion = cpuAddr[`SATURN_REGION_LO-1] ? saturnBusPkg::regSram
			                                         : saturnBusPkg::regSmpc;
		end
		else if (granule == RegW'(2)) nextRegion = saturnBusPkg::regRamL;
		else if (granule == RegW'(6)) nextRegion = saturnBusPkg::regRamH;
		else if (granule[RegW-1 -: 2] == 2'b10) begin // A-bus
			case (sub)
				2'b00, 2'b01: nextRegion = saturnBusPkg::regCart;
				2'b10:        nextRegion = saturnBusPkg::regCd;
				default:      nextRegion = saturnBusPkg::regAbusNone;
			endcase
		end
		else if (granule[RegW-1 -: 2] == 2'b11) begin // B-bus
			case (sub)
				2'b00:   nextRegion = saturnBusPkg::regVdp1;
				2'b01:   nextRegion = saturnBusPkg::regVdp2;
				2'b10:   nextRegion = saturnBusPkg::regScsp;
				default: nextRegion = saturnBusPkg::regNone;
			endcase
		end
	end

	always_comb begin
		case (region)
			saturnBusPkg::regRom, saturnBusPkg::regSram,
			saturnBusPkg::regRamL, saturnBusPkg::regRamH: regionRdy = memRdy;
			saturnBusPkg::regCart, saturnBusPkg::regCd:   regionRdy = aBusRdy;
			saturnBusPkg::regVdp1, saturnBusPkg::regVdp2,
			saturnBusPkg::regScsp:                        regionRdy = bBusRdy;
			default:                                      regionRdy = 1'b1;
		endcase
	end

	assign inAccess = state == saturnBusPkg::stAccess;
	assign accept   = cpuStart && state == saturnBusPkg::stIdle; // Starts during access are dropped

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state  <= saturnBusPkg::stIdle;
			region <= saturnBusPkg::regNone;
			readQ  <= 1'b0;
		end else if (accept) begin
			state  <= saturnBusPkg::stAccess;
			region <= nextRegion;
			readQ  <= cpuRead;
		end else if (inAccess && regionRdy) begin
			state <= saturnBusPkg::stIdle;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) memAddr <= cpuAddr;
	end

	assign isMem = region inside {saturnBusPkg::regRom, saturnBusPkg::regSram,
		saturnBusPkg::regRamL, saturnBusPkg::regRamH};

	assign romCsN  = !(inAccess && region == saturnBusPkg::regRom);
	assign sramCsN = !(inAccess && region == saturnBusPkg::regSram);
	assign ramLCsN = !(inAccess && region == saturnBusPkg::regRamL);
	assign ramHCsN = !(inAccess && region == saturnBusPkg::regRamH);
	assign memRdN  = !(inAccess && isMem && readQ);
	assign aCsN    = !(inAccess && region inside {saturnBusPkg::regCart, saturnBusPkg::regCd});
	assign bCsN    = !(inAccess && region inside {saturnBusPkg::regVdp1, saturnBusPkg::regVdp2,
		saturnBusPkg::regScsp});
	assign cpuDone = inAccess && regionRdy;
	assign aSel    = memAddr[`SATURN_SUBREGION_HI:`SATURN_SUBREGION_LO];
	assign bSel    = memAddr[`SATURN_SUBREGION_HI:`SATURN_SUBREGION_LO];

endmodule

// File: rtl/saturnBus.sv
`include "saturnBus_config.svh"

module saturnBus (
	input  logic                    CLK,
	input  logic                    RST_N,

	input  logic                    cpuStart,
	input  logic                    cpuRead,
	input  saturnBusPkg::busAddrT   cpuAddr,
	input  saturnBusPkg::busDataT   cpuWrData,
	input  logic [3:0]              cpuDqmN,
	output saturnBusPkg::busDataT   cpuRdData,
	output logic                    cpuDone,

	output saturnBusPkg::busAddrT   memAddr,
	output saturnBusPkg::busDataT   memWrData,
	output logic [3:0]              memDqmN,
	input  saturnBusPkg::busDataT   memRdData,
	input  logic                    memRdy,
	output logic                    memRdN,
	output logic                    romCsN,
	output logic                    sramCsN,
	output logic                    ramLCsN,
	output logic                    ramHCsN,

	input  saturnBusPkg::byteT      smpcRdData,

	output logic                    aCsN,
	output logic [`SATURN_SUBREGION_HI-`SATURN_SUBREGION_LO:0] aSel,
	output saturnBusPkg::subDataT   aWrData,
	input  logic                    aBusRdy,
	input  saturnBusPkg::subDataT   cartRdData,
	input  saturnBusPkg::subDataT   cdRdData,

	output logic                    bCsN,
	output logic [`SATURN_SUBREGION_HI-`SATURN_SUBREGION_LO:0] bSel,
	output saturnBusPkg::subDataT   bWrData,
	input  logic                    bBusRdy,
	input  saturnBusPkg::subDataT   vdp1RdData,
	input  saturnBusPkg::subDataT   vdp2RdData,
	input  saturnBusPkg::subDataT   scspRdData,

	input  logic                    cdCe,
	input  logic                    smpcCe,
	output logic                    shCeR,
	output logic                    shCeF,
	output logic                    mresN,

	input  saturnBusPkg::cdAddrT    shAddr,
	input  saturnBusPkg::subDataT   shWrData,
	input  saturnBusPkg::subDataT   dmaData,
	input  saturnBusPkg::subDataT   cdRamRdData,
	input  saturnBusPkg::subDataT   ctrlRdData,
	input  logic                    shCs1N,
	input  logic                    shRdN,
	input  logic                    shWrLN,
	input  logic                    shWrHN,
	input  logic                    cdRamRdy,
	input  logic [1:0]              dmaAckN,
	output saturnBusPkg::cdRamAddrT cdRamAddr,
	output saturnBusPkg::subDataT   cdRamWrData,
	output saturnBusPkg::subDataT   shRdData,
	output logic [1:0]              cdRamWe,
	output logic                    cdRamRd,
	output logic                    cdRamCs,
	output logic                    shWait
);

	saturnBusPkg::busRegionT region; // Held region of the access in flight

	assign memWrData = cpuWrData;
	assign memDqmN   = cpuDqmN;
	// Slave buses are 16 bits wide
	assign aWrData   = cpuWrData[`SATURN_SUB_DATA_W-1:0];
	assign bWrData   = cpuWrData[`SATURN_SUB_DATA_W-1:0];

	cpuBusDecode uDecode (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.cpuStart (cpuStart),
		.cpuRead  (cpuRead),
		.cpuAddr  (cpuAddr),
		.memRdy   (memRdy),
		.aBusRdy  (aBusRdy),
		.bBusRdy  (bBusRdy),
		.region   (region),
		.memAddr  (memAddr),
		.romCsN   (romCsN),
		.sramCsN  (sramCsN),
		.ramLCsN  (ramLCsN),
		.ramHCsN  (ramHCsN),
		.memRdN   (memRdN),
		.aCsN     (aCsN),
		.bCsN     (bCsN),
		.cpuDone  (cpuDone),
		.aSel     (aSel),
		.bSel     (bSel)
	);

	busReturnMux uReturn (
		.region     (region),
		.memRdData  (memRdData),
		.smpcRdData (smpcRdData),
		.cartRdData (cartRdData),
		.cdRdData   (cdRdData),
		.vdp1RdData (vdp1RdData),
		.vdp2RdData (vdp2RdData),
		.scspRdData (scspRdData),
		.cpuRdData  (cpuRdData)
	);

	clockResetGen uClkRst (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.cdCe   (cdCe),
		.smpcCe (smpcCe),
		.shCeR  (shCeR),
		.shCeF  (shCeF),
		.mresN  (mresN)
	);

	cdRamPort uCdRam (
		.shAddr      (shAddr),
		.shWrData    (shWrData),
		.dmaData     (dmaData),
		.cdRamRdData (cdRamRdData),
		.ctrlRdData  (ctrlRdData),
		.shCs1N      (shCs1N),
		.shRdN       (shRdN),
		.shWrLN      (shWrLN),
		.shWrHN      (shWrHN),
		.cdRamRdy    (cdRamRdy),
		.dmaAckN     (dmaAckN),
		.cdRamAddr   (cdRamAddr),
		.cdRamWrData (cdRamWrData),
		.shRdData    (shRdData),
		.cdRamWe     (cdRamWe),
		.cdRamRd     (cdRamRd),
		.cdRamCs     (cdRamCs),
		.shWait      (shWait)
	);

endmodule

// File: rtl/saturnBusPkg.sv
`include "saturnBus_config.svh"

package saturnBusPkg;

	typedef logic [`SATURN_BUS_ADDR_W-1:0]    busAddrT;
	typedef logic [`SATURN_BUS_DATA_W-1:0]    busDataT;
	typedef logic [`SATURN_SUB_DATA_W-1:0]    subDataT;
	typedef logic [7:0]                       byteT;     // SMPC register byte
	typedef logic [`SATURN_CD_ADDR_W-1:0]     cdAddrT;
	typedef logic [`SATURN_CD_RAM_ADDR_W-1:0] cdRamAddrT;

	typedef enum logic [3:0] {
		regRom,
		regSmpc,
		regSram,
		regRamL,
		regRamH,
		regCart,
		regCd,
		regAbusNone, // A-bus slot with no slave, reads back all ones
		regVdp1,
		regVdp2,
		regScsp,
		regNone
	} busRegionT;

	typedef enum logic {
		stIdle,
		stAccess
	} accessStateT;

endpackage

// File: rtl/saturnBus_config.svh
`ifndef SATURN_BUS_CONFIG_SVH
`define SATURN_BUS_CONFIG_SVH

// Main CPU bus
`define SATURN_BUS_ADDR_W 25
`define SATURN_BUS_DATA_W 32

// A-bus, B-bus and CD sub-CPU data
`define SATURN_SUB_DATA_W 16

// CD sub-CPU side
`define SATURN_CD_ADDR_W     21
`define SATURN_CD_RAM_ADDR_W 18

// 1 MB granule select
`define SATURN_REGION_HI 24
`define SATURN_REGION_LO 20

// Slave select inside A-bus and B-bus
`define SATURN_SUBREGION_HI 22
`define SATURN_SUBREGION_LO 21

`endif

// File: saturnBus.f
+incdir+rtl
rtl/saturnBusPkg.sv
rtl/cpuBusDecode.sv
rtl/busReturnMux.sv
rtl/clockResetGen.sv
rtl/cdRamPort.sv
rtl/saturnBus.sv
tests/saturnBus_properties.sv
tests/saturnBusTb.sv

// File: tests/saturnBusTb.sv
module saturnBusTb;

	localparam int maxWait = 64;

	logic CLK = 1'b0;
	logic RST_N;
	logic cpuStart, cpuRead, cpuDone, memRdy, memRdN, aBusRdy, bBusRdy;
	logic romCsN, sramCsN, ramLCsN, ramHCsN, aCsN, bCsN;
	logic cdCe, smpcCe, shCeR, shCeF, mresN, cdRamRd, cdRamCs, shWait;
	logic shCs1N, shRdN, shWrLN, shWrHN, cdRamRdy;
	logic [1:0] aSel, bSel, dmaAckN, cdRamWe;
	logic [3:0] cpuDqmN, memDqmN;
	logic [6:0] strobesN;
	saturnBusPkg::busAddrT   cpuAddr, memAddr;
	saturnBusPkg::busDataT   cpuWrData, cpuRdData, memWrData, memRdData;
	saturnBusPkg::byteT      smpcRdData;
	saturnBusPkg::subDataT   cartRdData, cdRdData, vdp1RdData, vdp2RdData, scspRdData;
	saturnBusPkg::subDataT   aWrData, bWrData, shWrData, dmaData, cdRamRdData, ctrlRdData;
	saturnBusPkg::subDataT   cdRamWrData, shRdData;
	saturnBusPkg::cdAddrT    shAddr;
	saturnBusPkg::cdRamAddrT cdRamAddr;

	int   seed = 37;
	int   errCount = 0;
	int   testMark = 0;
	int   testCount = 0;
	int   testFails = 0;
	logic cdRun = 1'b0;

	saturnBus uut (.*);

	always #2 CLK = ~CLK;

	assign strobesN = {memRdN, romCsN, sramCsN, ramLCsN, ramHCsN, aCsN, bCsN};

	// Slave models with fresh data and ready every cycle
	always @(posedge CLK) begin
		memRdy     <= 1'($random(seed));
		aBusRdy    <= 1'($random(seed));
		bBusRdy    <= 1'($random(seed));
		memRdData  <= $random(seed);
		smpcRdData <= 8'($random(seed));
		cartRdData <= 16'($random(seed));
		cdRdData   <= 16'($random(seed));
		vdp1RdData <= 16'($random(seed));
		vdp2RdData <= 16'($random(seed));
		scspRdData <= 16'($random(seed));
		cdCe       <= cdRun ? 1'($random(seed)) : 1'b0;
	end

	function automatic int totalErrors();
		return errCount + uut.props.failCount;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp);
			errCount++;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (totalErrors() == testMark) $display("Test %0d %s: ok", testCount, name);
		else begin
			$display("Test %0d %s: %0d errors", testCount, name, totalErrors() - testMark);
			testFails++;
		end
		testMark = totalErrors();
	endtask

	// One CPU access that returns at the negedge of the done cycle
	task automatic access(input saturnBusPkg::busAddrT addr, input logic rd,
		input logic [6:0] expStrobesN, output int cycles);
		@(posedge CLK);
		cpuStart  <= 1'b1;
		cpuAddr   <= addr;
		cpuRead   <= rd;
		cpuWrData <= $random(seed);
		cpuDqmN   <= 4'($random(seed));
		@(posedge CLK);
		cpuStart <= 1'b0;
		for (cycles = 1; cycles <= maxWait; cycles++) begin
			@(negedge CLK);
			checkEq("strobesN", 32'(strobesN), 32'(expStrobesN));
			if (cpuDone) break;
		end
		if (!cpuDone) begin
			$display("Timeout: no cpuDone within %0d cycles for address %h", maxWait, addr);
			errCount++;
		end
	endtask

	initial begin
		saturnBusPkg::busAddrT addr;
		logic [6:0]            expStrobesN;
		logic [15:0]           exp16;
		logic                  rd;
		int                    cycles;
		int                    sub;
		int                    nF;
		int                    nR;
		RST_N = 1'b0;
		cpuStart = 1'b0;
		cpuRead = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuDqmN = 4'hf;
		{memRdy, aBusRdy, bBusRdy, cdCe, smpcCe} = '0;
		{memRdData, smpcRdData, cartRdData, cdRdData} = '0;
		{vdp1RdData, vdp2RdData, scspRdData} = '0;
		{shAddr, shWrData, dmaData, cdRamRdData, ctrlRdData} = '0;
		{shCs1N, shRdN, shWrLN, shWrHN, dmaAckN} = '1;
		cdRamRdy = 1'b0;
		repeat (10) @(posedge CLK);
		RST_N <= 1'b1;

		repeat (3) begin
			@(negedge CLK);
			checkEq("strobesN", 32'(strobesN), 32'h7f);
			checkEq("cpuDone", 32'(cpuDone), 32'd0);
			checkEq("shCeR", 32'(shCeR), 32'd0);
			checkEq("shCeF", 32'(shCeF), 32'd0);
		end
		endTest("reset state");

		for (int i = 0; i < 16; i++) begin
			addr = saturnBusPkg::busAddrT'($random(seed));
			case (i % 4)
				0: addr[24:20] = 5'd0;
				1: addr[24:19] = 6'b000011; // Upper half of granule 1
				2: addr[24:20] = 5'd2;
				default: addr[24:20] = 5'd6;
			endcase
			rd = 1'($random(seed));
			expStrobesN = {!rd, 6'h3f & ~(6'h20 >> (i % 4))};
			access(addr, rd, expStrobesN, cycles);
			checkEq("memRdy", 32'(memRdy), 32'd1);
			checkEq("cpuRdData", cpuRdData, memRdData);
			checkEq("memAddr", 32'(memAddr), 32'(addr));
			checkEq("memWrData", memWrData, cpuWrData);
			checkEq("memDqmN", 32'(memDqmN), 32'(cpuDqmN));
		end
		endTest("memory regions");

		for (int i = 0; i < 8; i++) begin
			addr = saturnBusPkg::busAddrT'($random(seed));
			if (i % 2 == 0) addr[24:19] = 6'b000010;
			else addr[24:20] = 5'd3 + 5'(i % 3); // Unmapped granules 3 to 5
			access(addr, 1'b1, 7'h7f, cycles);
			checkEq("cycles to cpuDone", 32'(cycles), 32'd1);
			checkEq("cpuRdData", cpuRdData, (i % 2 == 0) ? {4{smpcRdData}} : 32'h0);
		end
		endTest("SMPC and unmapped");

		for (int i = 0; i < 16; i++) begin
			addr = saturnBusPkg::busAddrT'($random(seed));
			sub = i % 4;
			addr[24:23] = (i < 8) ? 2'b10 : 2'b11;
			addr[22:21] = 2'(sub);
			if (i < 8) begin
				access(addr, 1'b1, (sub == 3) ? 7'h7f : 7'h7d, cycles);
				if (sub != 3) checkEq("aBusRdy", 32'(aBusRdy), 32'd1);
				exp16 = (sub == 3) ? 16'hffff : (sub == 2) ? cdRdData : cartRdData;
				checkEq("aSel", 32'(aSel), 32'(sub));
				checkEq("aWrData", 32'(aWrData), 32'(cpuWrData[15:0]));
			end else begin
				access(addr, 1'b1, (sub == 3) ? 7'h7f : 7'h7e, cycles);
				if (sub != 3) checkEq("bBusRdy", 32'(bBusRdy), 32'd1);
				exp16 = (sub == 0) ? vdp1RdData : (sub == 1) ? vdp2RdData :
					(sub == 2) ? scspRdData : 16'h0;
				checkEq("bSel", 32'(bSel), 32'(sub));
				checkEq("bWrData", 32'(bWrData), 32'(cpuWrData[15:0]));
			end
			checkEq("cpuRdData", cpuRdData, {2{exp16}});
		end
		endTest("A-bus and B-bus");

		nF = 0;
		nR = 0;
		@(posedge CLK);
		cdRun <= 1'b1;
		repeat (40) begin
			@(negedge CLK);
			if (shCeF) nF++;
			if (shCeR) nR++;
			checkEq("mresN", 32'(mresN), 32'd0);
		end
		checkEq("shCeF count", 32'(nF > 0 && (nF == nR || nF == nR + 1)), 32'd1);
		@(posedge CLK);
		smpcCe <= 1'b1;
		@(negedge CLK);
		checkEq("mresN", 32'(mresN), 32'd0);
		@(posedge CLK);
		smpcCe <= 1'b0;
		@(negedge CLK);
		checkEq("mresN", 32'(mresN), 32'd1);
		endTest("CD clock enables and reset release");

		for (int i = 0; i < 24; i++) begin
			@(posedge CLK);
			shAddr      <= saturnBusPkg::cdAddrT'($random(seed));
			shWrData    <= 16'($random(seed));
			dmaData     <= 16'($random(seed));
			cdRamRdData <= 16'($random(seed));
			ctrlRdData  <= 16'($random(seed));
			{shCs1N, shRdN, shWrLN, shWrHN, cdRamRdy} <= 5'($random(seed));
			dmaAckN     <= 2'($random(seed));
			@(negedge CLK);
			checkEq("cdRamAddr", 32'(cdRamAddr), 32'(shAddr[17:0]));
			checkEq("cdRamWrData", 32'(cdRamWrData),
				32'((dmaAckN != 2'b11) ? dmaData : shWrData));
			checkEq("shRdData", 32'(shRdData), 32'(shCs1N ? ctrlRdData : cdRamRdData));
			checkEq("cdRamCs", 32'(cdRamCs), 32'(!shCs1N));
			checkEq("cdRamRd", 32'(cdRamRd), 32'(!shRdN));
			checkEq("cdRamWe", 32'(cdRamWe), 32'({!shWrHN, !shWrLN}));
			checkEq("shWait", 32'(shWait), 32'(cdRamRdy));
		end
		endTest("CD RAM port");

		@(negedge CLK);
		$display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
			testCount, testFails, errCount, uut.props.failCount);
		if (testFails == 0 && totalErrors() == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: tests/saturnBus_properties.sv
module saturnBusProperties (
	input logic CLK,
	input logic RST_N,
	input logic cpuDone,
	input logic memRdy,
	input logic aBusRdy,
	input logic bBusRdy,
	input logic romCsN,
	input logic sramCsN,
	input logic ramLCsN,
	input logic ramHCsN,
	input logic aCsN,
	input logic bCsN,
	input logic cdCe,
	input logic smpcCe,
	input logic shCeR,
	input logic shCeF,
	input logic mresN
);

	int         failCount = 0;
	logic       nextIsF; // Which half-rate enable is due next
	logic [5:0] csN;

	assign csN = {romCsN, sramCsN, ramLCsN, ramHCsN, aCsN, bCsN};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) nextIsF <= 1'b1;
		else if (shCeF) nextIsF <= 1'b0;
		else if (shCeR) nextIsF <= 1'b1;
	end

	csOneHot: assert property (@(posedge CLK) disable iff (!RST_N) $onehot0(~csN))
		else begin $error("more than one chip select low"); failCount++; end
	csHeld: assert property (@(posedge CLK) disable iff (!RST_N)
		(csN != '1 && !cpuDone) |=> $stable(csN))
		else begin $error("chip select changed before cpuDone"); failCount++; end
	csRelease: assert property (@(posedge CLK) disable iff (!RST_N) cpuDone |=> csN == '1)
		else begin $error("chip select still low after cpuDone"); failCount++; end

	// Done only on the ready of the bus in use
	memDoneRdy: assert property (@(posedge CLK) disable iff (!RST_N)
		(cpuDone && csN[5:2] != '1) |-> memRdy)
		else begin $error("memory access done without memRdy"); failCount++; end
	aDoneRdy: assert property (@(posedge CLK) disable iff (!RST_N) (cpuDone && !aCsN) |-> aBusRdy)
		else begin $error("A-bus access done without aBusRdy"); failCount++; end
	bDoneRdy: assert property (@(posedge CLK) disable iff (!RST_N) (cpuDone && !bCsN) |-> bBusRdy)
		else begin $error("B-bus access done without bBusRdy"); failCount++; end

	ceExclusive: assert property (@(posedge CLK) disable iff (!RST_N) !(shCeR && shCeF))
		else begin $error("shCeR and shCeF high together"); failCount++; end
	ceNeedsCdCe: assert property (@(posedge CLK) disable iff (!RST_N) (shCeR || shCeF) |-> cdCe)
		else begin $error("CD clock enable without cdCe"); failCount++; end
	ceOrder: assert property (@(posedge CLK) disable iff (!RST_N)
		(shCeR || shCeF) |-> shCeF == nextIsF)
		else begin $error("shCeR and shCeF out of order"); failCount++; end

	mresHold: assert property (@(posedge CLK) disable iff (!RST_N) (!mresN && !smpcCe) |=> !mresN)
		else begin $error("mresN released without smpcCe"); failCount++; end
	mresRise: assert property (@(posedge CLK) disable iff (!RST_N) smpcCe |=> mresN)
		else begin $error("mresN not released after smpcCe"); failCount++; end
	mresStay: assert property (@(posedge CLK) disable iff (!RST_N) mresN |=> mresN)
		else begin $error("mresN dropped after release"); failCount++; end

endmodule

bind saturnBus saturnBusProperties props (
	.CLK(CLK), .RST_N(RST_N), .cpuDone(cpuDone),
	.memRdy(memRdy), .aBusRdy(aBusRdy), .bBusRdy(bBusRdy),
	.romCsN(romCsN), .sramCsN(sramCsN), .ramLCsN(ramLCsN), .ramHCsN(ramHCsN),
	.aCsN(aCsN), .bCsN(bCsN), .cdCe(cdCe), .smpcCe(smpcCe),
	.shCeR(shCeR), .shCeF(shCeF), .mresN(mresN)
);
